//--- logic/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_REGIMM   6'b000001
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDI     6'b001000
`define OP_ADDIU    6'b001001
`define OP_SLTI     6'b001010
`define OP_SLTIU    6'b001011
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_XORI     6'b001110
`define OP_LUI      6'b001111
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_LBU      6'b100100
`define OP_LHU      6'b100101
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011

// funct codes under SPECIAL
`define F_SLL       6'b000000
`define F_SRL       6'b000010
`define F_SRA       6'b000011
`define F_SLLV      6'b000100
`define F_SRLV      6'b000110
`define F_SRAV      6'b000111
`define F_JR        6'b001000
`define F_JALR      6'b001001
`define F_SYSCALL   6'b001100
`define F_BREAK     6'b001101
`define F_ADD       6'b100000
`define F_ADDU      6'b100001
`define F_SUB       6'b100010
`define F_SUBU      6'b100011
`define F_AND       6'b100100
`define F_OR        6'b100101
`define F_XOR       6'b100110
`define F_NOR       6'b100111
`define F_SLT       6'b101010
`define F_SLTU      6'b101011

// REGIMM codes in the rt field
`define B_BLTZ      5'b00000
`define B_BGEZ      5'b00001
`define B_BLTZAL    5'b10000
`define B_BGEZAL    5'b10001

`define LINK_REG    5'd31

// low bit of each instruction field
`define OPCODE_POS  26
`define RS_POS      21
`define RT_POS      16
`define RD_POS      11
`define SHAMT_POS   6
`define FUNCT_POS   0

`endif

//--- logic/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    typedef logic [4:0] reg_addr_t;

    // R-type layout
    typedef struct packed {
        logic [31-`OPCODE_POS:0]          opcode;
        logic [`OPCODE_POS-`RS_POS-1:0]   rs;
        logic [`RS_POS-`RT_POS-1:0]       rt;
        logic [`RT_POS-`RD_POS-1:0]       rd;
        logic [`RD_POS-`SHAMT_POS-1:0]    shamt;
        logic [`SHAMT_POS-`FUNCT_POS-1:0] funct;
    } r_fmt_t;

    // I-type layout with imm16 below rt
    typedef struct packed {
        logic [31-`OPCODE_POS:0]          opcode;
        logic [`OPCODE_POS-`RS_POS-1:0]   rs;
        logic [`RS_POS-`RT_POS-1:0]       rt;
        logic [`RT_POS-1:0]               imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_view;
        i_fmt_t i_view;
    } instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU, ALU_AND, ALU_OR,
        ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASSA
    } alu_func_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BGEZ, BR_BLTZ, BR_BGTZ, BR_BLEZ
    } branch_type_e;

    typedef enum logic [1:0] {
        MSIZE_NONE, MSIZE_BYTE, MSIZE_HALF, MSIZE_WORD
    } msize_e;

    typedef struct packed {
        alu_func_e    alufunc;
        logic         alusrc_imm;
        logic         zeroext;
        logic         shamt_valid;
        logic         regwrite;
        logic         memtoreg;
        logic         memwrite;
        logic         memsext;
        msize_e       msize;
        branch_type_e branch_type;
        logic         jump;
        logic         jr;
        logic         is_link;
    } decode_ctl_t;

    typedef struct packed {
        reg_addr_t srcrega;
        reg_addr_t srcregb;
        reg_addr_t destreg;
    } reg_sel_t;

    typedef struct packed {
        logic reserved;
        logic syscall;
        logic breakpoint;
    } exc_t;

endpackage

//--- logic/special_decoder.sv
`timescale 1ns/10ps
`include "decode_macros.svh"

module special_decoder (
    input  decode_pkg::instr_u      instr,
    output decode_pkg::decode_ctl_t ctl,
    output decode_pkg::reg_sel_t    regs,
    output decode_pkg::exc_t        exc
);

    decode_pkg::alu_func_e op;
    // rs, rt -> rd
    logic rform;
    // shift by shamt, rt -> rd
    logic sform;

    always_comb begin
        op = decode_pkg::ALU_ADD;
        rform = 1'b0;
        sform = 1'b0;
        case (instr.r_view.funct)
            `F_ADD:  begin op = decode_pkg::ALU_ADD;  rform = 1'b1; end
            `F_ADDU: begin op = decode_pkg::ALU_ADDU; rform = 1'b1; end
            `F_SUB:  begin op = decode_pkg::ALU_SUB;  rform = 1'b1; end
            `F_SUBU: begin op = decode_pkg::ALU_SUBU; rform = 1'b1; end
            `F_SLT:  begin op = decode_pkg::ALU_SLT;  rform = 1'b1; end
            `F_SLTU: begin op = decode_pkg::ALU_SLTU; rform = 1'b1; end
            `F_AND:  begin op = decode_pkg::ALU_AND;  rform = 1'b1; end
            `F_OR:   begin op = decode_pkg::ALU_OR;   rform = 1'b1; end
            `F_XOR:  begin op = decode_pkg::ALU_XOR;  rform = 1'b1; end
            `F_NOR:  begin op = decode_pkg::ALU_NOR;  rform = 1'b1; end
            `F_SLLV: begin op = decode_pkg::ALU_SLL;  rform = 1'b1; end
            `F_SRLV: begin op = decode_pkg::ALU_SRL;  rform = 1'b1; end
            `F_SRAV: begin op = decode_pkg::ALU_SRA;  rform = 1'b1; end
            `F_SLL:  begin op = decode_pkg::ALU_SLL;  sform = 1'b1; end
            `F_SRL:  begin op = decode_pkg::ALU_SRL;  sform = 1'b1; end
            `F_SRA:  begin op = decode_pkg::ALU_SRA;  sform = 1'b1; end
            default: ;
        endcase
    end

    always_comb begin
        ctl = '0;
        regs = '0;
        exc = '0;
        if (rform || sform) begin
            ctl.alufunc = op;
            ctl.regwrite = 1'b1;
            ctl.shamt_valid = sform;
            regs.srcrega = rform ? instr.r_view.rs : '0;
            regs.srcregb = instr.r_view.rt;
            regs.destreg = instr.r_view.rd;
        end else begin
            case (instr.r_view.funct)
                `F_JR: begin
                    ctl.jump = 1'b1;
                    ctl.jr = 1'b1;
                    regs.srcrega = instr.r_view.rs;
                end
                `F_JALR: begin
                    ctl.jump = 1'b1;
                    ctl.jr = 1'b1;
                    ctl.regwrite = 1'b1;
                    ctl.is_link = 1'b1;
                    regs.srcrega = instr.r_view.rs;
                    // link register comes from rd here
                    regs.destreg = instr.r_view.rd;
                end
                `F_SYSCALL: begin
                    ctl.alufunc = decode_pkg::ALU_PASSA;
                    exc.syscall = 1'b1;
                end
                `F_BREAK: begin
                    ctl.alufunc = decode_pkg::ALU_PASSA;
                    exc.breakpoint = 1'b1;
                end
                default: exc.reserved = 1'b1;
            endcase
        end
    end

endmodule

//--- logic/primary_decoder.sv
`timescale 1ns/10ps
`include "decode_macros.svh"

module primary_decoder (
    input  decode_pkg::instr_u      instr,
    output decode_pkg::decode_ctl_t ctl,
    output decode_pkg::reg_sel_t    regs,
    output decode_pkg::exc_t        exc
);

    decode_pkg::decode_ctl_t sp_ctl;
    decode_pkg::reg_sel_t    sp_regs;
    decode_pkg::exc_t        sp_exc;
    decode_pkg::alu_func_e   imm_op;
    decode_pkg::msize_e      mem_size;
    logic                    mem_sext;

    special_decoder u_special (
        .instr (instr),
        .ctl   (sp_ctl),
        .regs  (sp_regs),
        .exc   (sp_exc)
    );

    // per-opcode ALU op and access size
    always_comb begin
        imm_op = decode_pkg::ALU_ADD;
        mem_size = decode_pkg::MSIZE_NONE;
        mem_sext = 1'b0;
        case (instr.i_view.opcode)
            `OP_ADDIU: imm_op = decode_pkg::ALU_ADDU;
            `OP_SLTI:  imm_op = decode_pkg::ALU_SLT;
            `OP_SLTIU: imm_op = decode_pkg::ALU_SLTU;
            `OP_ANDI:  imm_op = decode_pkg::ALU_AND;
            `OP_ORI:   imm_op = decode_pkg::ALU_OR;
            `OP_XORI:  imm_op = decode_pkg::ALU_XOR;
            `OP_LUI:   imm_op = decode_pkg::ALU_LUI;
            `OP_LB:    begin mem_size = decode_pkg::MSIZE_BYTE; mem_sext = 1'b1; end
            `OP_LH:    begin mem_size = decode_pkg::MSIZE_HALF; mem_sext = 1'b1; end
            `OP_LBU, `OP_SB: mem_size = decode_pkg::MSIZE_BYTE;
            `OP_LHU, `OP_SH: mem_size = decode_pkg::MSIZE_HALF;
            `OP_LW, `OP_SW:  mem_size = decode_pkg::MSIZE_WORD;
            default: ;
        endcase
    end

    always_comb begin
        ctl = '0;
        regs = '0;
        exc = '0;
        case (instr.i_view.opcode)
            `OP_SPECIAL: begin
                ctl = sp_ctl;
                regs = sp_regs;
                exc = sp_exc;
            end
            `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
            `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                ctl.alufunc = imm_op;
                ctl.alusrc_imm = 1'b1;
                ctl.regwrite = 1'b1;
                ctl.zeroext = (imm_op == decode_pkg::ALU_AND) || (imm_op == decode_pkg::ALU_OR)
                              || (imm_op == decode_pkg::ALU_XOR);
                regs.srcrega = (imm_op == decode_pkg::ALU_LUI) ? '0 : instr.i_view.rs;
                regs.destreg = instr.i_view.rt;
            end
            `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
                ctl.alufunc = decode_pkg::ALU_ADDU;
                ctl.alusrc_imm = 1'b1;
                ctl.regwrite = 1'b1;
                ctl.memtoreg = 1'b1;
                ctl.memsext = mem_sext;
                ctl.msize = mem_size;
                regs.srcrega = instr.i_view.rs;
                regs.destreg = instr.i_view.rt;
            end
            `OP_SB, `OP_SH, `OP_SW: begin
                ctl.alufunc = decode_pkg::ALU_ADDU;
                ctl.alusrc_imm = 1'b1;
                ctl.memwrite = 1'b1;
                ctl.msize = mem_size;
                regs.srcrega = instr.i_view.rs;
                regs.srcregb = instr.i_view.rt;
            end
            `OP_BEQ, `OP_BNE: begin
                ctl.branch_type = (instr.i_view.opcode == `OP_BEQ) ? decode_pkg::BR_BEQ
                                                                   : decode_pkg::BR_BNE;
                regs.srcrega = instr.i_view.rs;
                regs.srcregb = instr.i_view.rt;
            end
            `OP_BLEZ, `OP_BGTZ: begin
                ctl.branch_type = (instr.i_view.opcode == `OP_BLEZ) ? decode_pkg::BR_BLEZ
                                                                    : decode_pkg::BR_BGTZ;
                regs.srcrega = instr.i_view.rs;
            end
            `OP_J: ctl.jump = 1'b1;
            `OP_JAL: begin
                ctl.jump = 1'b1;
                ctl.regwrite = 1'b1;
                ctl.is_link = 1'b1;
                regs.destreg = `LINK_REG;
            end
            `OP_REGIMM: begin
                // rt selects the compare-with-zero branch
                case (instr.i_view.rt)
                    `B_BLTZ, `B_BLTZAL: ctl.branch_type = decode_pkg::BR_BLTZ;
                    `B_BGEZ, `B_BGEZAL: ctl.branch_type = decode_pkg::BR_BGEZ;
                    default: exc.reserved = 1'b1;
                endcase
                if (!exc.reserved) begin
                    regs.srcrega = instr.i_view.rs;
                end
                if (instr.i_view.rt == `B_BLTZAL || instr.i_view.rt == `B_BGEZAL) begin
                    ctl.regwrite = 1'b1;
                    ctl.is_link = 1'b1;
                    regs.destreg = `LINK_REG;
                end
            end
            default: exc.reserved = 1'b1;
        endcase
    end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  decode_pkg::instr_u      instr,
    output logic                    out_valid,
    output decode_pkg::decode_ctl_t ctl,
    output decode_pkg::reg_sel_t    regs,
    output decode_pkg::exc_t        exc
);

    decode_pkg::decode_ctl_t dec_ctl;
    decode_pkg::reg_sel_t    dec_regs;
    decode_pkg::exc_t        dec_exc;
    decode_pkg::decode_ctl_t next_ctl;
    decode_pkg::reg_sel_t    next_regs;
    decode_pkg::exc_t        next_exc;

    primary_decoder u_primary (
        .instr (instr),
        .ctl   (dec_ctl),
        .regs  (dec_regs),
        .exc   (dec_exc)
    );

    always_comb begin
        next_ctl = '0;
        next_regs = '0;
        next_exc = '0;
        // idle cycles register an all-zero decode
        if (in_valid) begin
            next_ctl = dec_ctl;
            next_regs = dec_regs;
            next_exc = dec_exc;
            // writes to r0 are dropped
            if (dec_regs.destreg == '0) begin
                next_ctl.regwrite = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            ctl <= '0;
            regs <= '0;
            exc <= '0;
        end else begin
            out_valid <= in_valid;
            ctl <= next_ctl;
            regs <= next_regs;
            exc <= next_exc;
        end
    end

endmodule

//--- verif/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always #2 clk = ~clk;

endmodule

//--- verif/instr_decoder_props.sv
`timescale 1ns/10ps

module instr_decoder_props (
    input logic                    clk,
    input logic                    reset,
    input logic                    out_valid,
    input decode_pkg::decode_ctl_t ctl,
    input decode_pkg::reg_sel_t    regs,
    input decode_pkg::exc_t        exc
);

    property idle_after_reset;
        @(posedge clk) reset |=> !out_valid;
    endproperty

    // r0 is never written
    property no_write_to_r0;
        @(posedge clk) disable iff (reset) ctl.regwrite |-> (regs.destreg != 5'd0);
    endproperty

    property reserved_is_inert;
        @(posedge clk) disable iff (reset) exc.reserved |-> !(ctl.regwrite || ctl.memwrite);
    endproperty

    assert property (idle_after_reset)
        else $error("out_valid high in the cycle after reset");
    assert property (no_write_to_r0)
        else $error("regwrite asserted with destreg zero");
    assert property (reserved_is_inert)
        else $error("reserved instruction with a register or memory write");

endmodule

//--- verif/instr_decoder_tb.sv
`timescale 1ns/10ps
`include "decode_macros.svh"

module instr_decoder_tb;

    typedef struct packed {
        logic                    valid;
        decode_pkg::decode_ctl_t ctl;
        decode_pkg::reg_sel_t    regs;
        decode_pkg::exc_t        exc;
    } expect_t;

    logic                    clk;
    logic                    reset;
    logic                    in_valid;
    decode_pkg::instr_u      instr;
    logic                    out_valid;
    decode_pkg::decode_ctl_t ctl;
    decode_pkg::reg_sel_t    regs;
    decode_pkg::exc_t        exc;

    expect_t            exp_q[$];
    expect_t            exp_item;
    decode_pkg::instr_u word;
    logic [31:0]        rnd;
    logic [31:0]        mix;
    integer             seed;
    int                 errors;
    int                 checked;
    int                 i;

    tb_clock u_clock (
        .clk (clk)
    );

    instr_decoder uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .ctl       (ctl),
        .regs      (regs),
        .exc       (exc)
    );

    bind instr_decoder instr_decoder_props u_props (
        .clk       (clk),
        .reset     (reset),
        .out_valid (out_valid),
        .ctl       (ctl),
        .regs      (regs),
        .exc       (exc)
    );

    function automatic expect_t decode_ref(input logic valid, input decode_pkg::instr_u w);
        expect_t               e;
        decode_pkg::alu_func_e alu;
        logic                  known;
        logic                  link;
        e = '0;
        alu = decode_pkg::ALU_ADD;
        known = 1'b1;
        link = 1'b0;
        e.valid = valid;
        if (valid) begin
            case (w.r_view.opcode)
                `OP_SPECIAL: begin
                    case (w.r_view.funct)
                        `F_ADD:  alu = decode_pkg::ALU_ADD;
                        `F_ADDU: alu = decode_pkg::ALU_ADDU;
                        `F_SUB:  alu = decode_pkg::ALU_SUB;
                        `F_SUBU: alu = decode_pkg::ALU_SUBU;
                        `F_SLT:  alu = decode_pkg::ALU_SLT;
                        `F_SLTU: alu = decode_pkg::ALU_SLTU;
                        `F_AND:  alu = decode_pkg::ALU_AND;
                        `F_OR:   alu = decode_pkg::ALU_OR;
                        `F_XOR:  alu = decode_pkg::ALU_XOR;
                        `F_NOR:  alu = decode_pkg::ALU_NOR;
                        `F_SLL, `F_SLLV: alu = decode_pkg::ALU_SLL;
                        `F_SRL, `F_SRLV: alu = decode_pkg::ALU_SRL;
                        `F_SRA, `F_SRAV: alu = decode_pkg::ALU_SRA;
                        default: known = 1'b0;
                    endcase
                    if (known) begin
                        e.ctl.alufunc = alu;
                        e.ctl.regwrite = 1'b1;
                        // shift-by-shamt forms sit below funct 4
                        e.ctl.shamt_valid = (w.r_view.funct[5:2] == 4'b0000);
                        e.regs = {e.ctl.shamt_valid ? 5'd0 : w.r_view.rs, w.r_view.rt, w.r_view.rd};
                    end else if (w.r_view.funct == `F_JR || w.r_view.funct == `F_JALR) begin
                        link = w.r_view.funct[0];
                        e.ctl.jump = 1'b1;
                        e.ctl.jr = 1'b1;
                        e.ctl.regwrite = link;
                        e.ctl.is_link = link;
                        e.regs = {w.r_view.rs, 5'd0, link ? w.r_view.rd : 5'd0};
                    end else if (w.r_view.funct == `F_SYSCALL || w.r_view.funct == `F_BREAK) begin
                        e.ctl.alufunc = decode_pkg::ALU_PASSA;
                        e.exc.syscall = !w.r_view.funct[0];
                        e.exc.breakpoint = w.r_view.funct[0];
                    end else begin
                        e.exc.reserved = 1'b1;
                    end
                end
                `OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
                    case (w.i_view.opcode[2:0])
                        3'd0: alu = decode_pkg::ALU_ADD;
                        3'd1: alu = decode_pkg::ALU_ADDU;
                        3'd2: alu = decode_pkg::ALU_SLT;
                        3'd3: alu = decode_pkg::ALU_SLTU;
                        3'd4: alu = decode_pkg::ALU_AND;
                        3'd5: alu = decode_pkg::ALU_OR;
                        3'd6: alu = decode_pkg::ALU_XOR;
                        default: alu = decode_pkg::ALU_LUI;
                    endcase
                    e.ctl.alufunc = alu;
                    e.ctl.alusrc_imm = 1'b1;
                    e.ctl.regwrite = 1'b1;
                    e.ctl.zeroext = (w.i_view.opcode[2:0] inside {3'd4, 3'd5, 3'd6});
                    e.regs = {(alu == decode_pkg::ALU_LUI) ? 5'd0 : w.i_view.rs, 5'd0, w.i_view.rt};
                end
                `OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW: begin
                    e.ctl.alufunc = decode_pkg::ALU_ADDU;
                    e.ctl.alusrc_imm = 1'b1;
                    case (w.i_view.opcode[1:0])
                        2'b00: e.ctl.msize = decode_pkg::MSIZE_BYTE;
                        2'b01: e.ctl.msize = decode_pkg::MSIZE_HALF;
                        default: e.ctl.msize = decode_pkg::MSIZE_WORD;
                    endcase
                    // opcode bit 3 marks a store
                    if (w.i_view.opcode[3]) begin
                        e.ctl.memwrite = 1'b1;
                        e.regs = {w.i_view.rs, w.i_view.rt, 5'd0};
                    end else begin
                        e.ctl.regwrite = 1'b1;
                        e.ctl.memtoreg = 1'b1;
                        e.ctl.memsext = (w.i_view.opcode == `OP_LB) || (w.i_view.opcode == `OP_LH);
                        e.regs = {w.i_view.rs, 5'd0, w.i_view.rt};
                    end
                end
                `OP_BEQ, `OP_BNE: begin
                    e.ctl.branch_type = w.i_view.opcode[0] ? decode_pkg::BR_BNE : decode_pkg::BR_BEQ;
                    e.regs = {w.i_view.rs, w.i_view.rt, 5'd0};
                end
                `OP_BLEZ, `OP_BGTZ: begin
                    e.ctl.branch_type = w.i_view.opcode[0] ? decode_pkg::BR_BGTZ
                                                           : decode_pkg::BR_BLEZ;
                    e.regs = {w.i_view.rs, 10'd0};
                end
                `OP_J: e.ctl.jump = 1'b1;
                `OP_JAL: begin
                    e.ctl.jump = 1'b1;
                    e.ctl.regwrite = 1'b1;
                    e.ctl.is_link = 1'b1;
                    e.regs = {10'd0, `LINK_REG};
                end
                `OP_REGIMM: begin
                    // only rt codes 0, 1, 16 and 17 exist
                    if (w.i_view.rt[3:1] == 3'b000) begin
                        link = w.i_view.rt[4];
                        e.ctl.branch_type = w.i_view.rt[0] ? decode_pkg::BR_BGEZ
                                                           : decode_pkg::BR_BLTZ;
                        e.ctl.regwrite = link;
                        e.ctl.is_link = link;
                        e.regs = {w.i_view.rs, 5'd0, link ? `LINK_REG : 5'd0};
                    end else begin
                        e.exc.reserved = 1'b1;
                    end
                end
                default: e.exc.reserved = 1'b1;
            endcase
            if (e.regs.destreg == 5'd0) begin
                e.ctl.regwrite = 1'b0;
            end
        end
        return e;
    endfunction

    function automatic logic [31:0] make_word(input logic [5:0] op, input logic [5:0] fn);
        decode_pkg::instr_u w;
        w = $random(seed);
        w.r_view.opcode = op;
        w.r_view.funct = fn;
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected %h got %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic send_word(input logic valid, input logic [31:0] w);
        @(negedge clk);
        in_valid = valid;
        instr = w;
    endtask

    task automatic wait_for_valid(input logic level);
        int n;
        n = 0;
        while (out_valid !== level && n < 10) begin
            @(negedge clk);
            n++;
        end
        if (out_valid !== level) begin
            $display("timeout: out_valid did not reach %0d within 10 cycles", level);
            errors++;
        end
    endtask

    // expected decode for each rising edge
    always @(posedge clk) begin
        exp_q.push_back(decode_ref(in_valid && !reset, instr));
    end

    always @(negedge clk) begin
        if (exp_q.size() > 0) begin
            exp_item = exp_q.pop_front();
            check_value("out_valid", 32'(exp_item.valid), 32'(out_valid));
            check_value("ctl", 32'(exp_item.ctl), 32'(ctl));
            check_value("regs", 32'(exp_item.regs), 32'(regs));
            check_value("exc", 32'(exp_item.exc), 32'(exc));
            checked++;
        end
    end

    initial begin
        seed = 77735;
        errors = 0;
        checked = 0;
        reset = 1'b1;
        in_valid = 1'b0;
        instr = '0;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        send_word(1'b1, make_word(`OP_ADDIU, 6'd0));
        wait_for_valid(1'b1);
        // every funct, every opcode, every REGIMM code
        for (i = 0; i < 64; i++) begin
            send_word(1'b1, make_word(`OP_SPECIAL, i[5:0]));
        end
        for (i = 0; i < 64; i++) begin
            rnd = $random(seed);
            send_word(1'b1, make_word(i[5:0], rnd[5:0]));
        end
        for (i = 0; i < 32; i++) begin
            word = make_word(`OP_REGIMM, 6'd0);
            word.i_view.rt = i[4:0];
            send_word(1'b1, word);
        end
        word = make_word(`OP_SPECIAL, `F_ADD);
        word.r_view.rd = 5'd0;
        send_word(1'b1, word);
        word = make_word(`OP_SPECIAL, `F_JALR);
        word.r_view.rd = 5'd0;
        send_word(1'b1, word);
        word = make_word(`OP_LW, 6'd0);
        word.i_view.rt = 5'd0;
        send_word(1'b1, word);

        for (i = 0; i < 300; i++) begin
            rnd = $random(seed);
            mix = $random(seed);
            word = rnd;
            if (mix[3:2] != 2'b00) begin
                word.r_view.opcode = word.r_view.opcode & 6'b101111;
            end
            send_word(mix[1:0] != 2'b00, word);
        end
        send_word(1'b0, $random(seed));
        wait_for_valid(1'b0);
        repeat (3) send_word(1'b0, $random(seed));
        @(posedge clk);

        if (checked == 0) begin
            $display("no decoder results were checked");
            errors++;
        end
        $display("decode checks finished with %0d errors over %0d results", errors, checked);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- instr_decoder.f
+incdir+logic
logic/decode_pkg.sv
logic/special_decoder.sv
logic/primary_decoder.sv
logic/instr_decoder.sv
verif/tb_clock.sv
verif/instr_decoder_props.sv
verif/instr_decoder_tb.sv

//--- Bender.yml
package:
  name: instr_decoder

sources:
  - include_dirs:
      - logic
    files:
      - logic/decode_pkg.sv
      - logic/special_decoder.sv
      - logic/primary_decoder.sv
      - logic/instr_decoder.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_clock.sv
      - verif/instr_decoder_props.sv
      - verif/instr_decoder_tb.sv
